// ==== hw/ctn_pkg.sv ====
/*
 * CTN memory path shared definitions.
 * Bus widths, response codes and the AXI4-Lite and RAM command structs.
 */
package ctn_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  localparam logic [1:0] RespOkay   = 2'd0;
  localparam logic [1:0] RespSlvErr = 2'd2;

  // Host to subsystem, one AXI4-Lite port
  typedef struct packed {
    logic                 aw_valid;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axil_req_t;

  // Subsystem to host
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    logic [1:0]           b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    logic [1:0]           r_resp;
  } axil_rsp_t;

  // Steering to adapter; idx is the full word address, the adapter keeps the low bits
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [AddrWidth-3:0]   idx;
    logic [DataWidth-1:0]   wdata;
    logic [StrbWidth-1:0]   wstrb;
  } ram_cmd_t;

  typedef struct packed {
    logic                 done;   // One cycle pulse
    logic [DataWidth-1:0] rdata;
  } ram_rsp_t;

endpackage : ctn_pkg

// ==== hw/ctn_host_arb.sv ====
/*
 * Two-host round-robin arbiter for AXI4-Lite.
 * One host owns the downstream port until its b or r handshake completes.
 */
`timescale 1ns/1ps

module ctn_host_arb (
  input  logic               clk_aon,
  input  logic               rst_n_i,
  input  ctn_pkg::axil_req_t host0_req_i,
  output ctn_pkg::axil_rsp_t host0_rsp_o,
  input  ctn_pkg::axil_req_t host1_req_i,
  output ctn_pkg::axil_rsp_t host1_rsp_o,
  output ctn_pkg::axil_req_t dev_req_o,
  input  ctn_pkg::axil_rsp_t dev_rsp_i
);

  import ctn_pkg::*;

  logic busy_q;   // A host holds the grant
  logic sel_q;    // Granted host
  logic prio_q;   // Host that wins a tie
  logic req0, req1;
  logic sel_d;
  logic txn_done;

  // A write counts only once both aw and w are up
  assign req0 = (host0_req_i.aw_valid & host0_req_i.w_valid) | host0_req_i.ar_valid;
  assign req1 = (host1_req_i.aw_valid & host1_req_i.w_valid) | host1_req_i.ar_valid;

  assign sel_d = (req0 & req1) ? prio_q : req1;

  assign txn_done = (dev_rsp_i.b_valid & dev_req_o.b_ready) |
                    (dev_rsp_i.r_valid & dev_req_o.r_ready);

  //////////////////////////////
  // Grant state
  //////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      sel_q  <= 1'b0;
      prio_q <= 1'b0;   // host0 first after reset
    end else if (!busy_q && (req0 || req1)) begin
      busy_q <= 1'b1;
      sel_q  <= sel_d;
      prio_q <= ~sel_d; // Last served loses the next tie
    end else if (busy_q && txn_done) begin
      busy_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Request and response muxing
  //////////////////////////////

  always_comb begin
    dev_req_o   = '0;
    host0_rsp_o = '0;
    host1_rsp_o = '0;
    if (busy_q) begin
      if (sel_q) begin
        dev_req_o   = host1_req_i;
        host1_rsp_o = dev_rsp_i;
      end else begin
        dev_req_o   = host0_req_i;
        host0_rsp_o = dev_rsp_i;
      end
    end
  end

endmodule : ctn_host_arb

// ==== hw/ctn_addr_steer.sv ====
/*
 * Address window check for the CTN scratch RAM.
 * In-window accesses become RAM commands; the rest get SLVERR.
 */
`timescale 1ns/1ps

module ctn_addr_steer #(
  parameter int unsigned                   RamDepth = 256,
  parameter logic [ctn_pkg::AddrWidth-1:0] RamBase  = 32'h0001_0000
) (
  input  logic               clk_aon,
  input  logic               rst_n_i,
  input  ctn_pkg::axil_req_t up_req_i,
  output ctn_pkg::axil_rsp_t up_rsp_o,
  output ctn_pkg::ram_cmd_t  ram_cmd_o,
  input  ctn_pkg::ram_rsp_t  ram_rsp_i
);

  import ctn_pkg::*;

  localparam logic [AddrWidth-1:0] WinBytes = AddrWidth'(RamDepth * 4);

  typedef enum logic [1:0] {
    StIdle,
    StRam,    // Waiting on the adapter
    StResp    // Holding b or r valid
  } state_e;

  state_e               state_q;
  logic                 is_wr_q;
  logic [1:0]           resp_q;
  logic [DataWidth-1:0] rdata_q;

  logic                 idle, wr_go, rd_go, accept, in_win, rsp_done;
  logic [AddrWidth-1:0] acc_addr;

  assign idle     = (state_q == StIdle);
  assign wr_go    = up_req_i.aw_valid & up_req_i.w_valid;
  assign rd_go    = up_req_i.ar_valid & ~wr_go;   // Write wins over read
  assign accept   = idle & (wr_go | rd_go);
  assign acc_addr = wr_go ? up_req_i.aw_addr : up_req_i.ar_addr;
  assign in_win   = (acc_addr & ~(WinBytes - 1'b1)) == RamBase;

  // Base is window aligned, so the low word bits are the RAM index
  assign ram_cmd_o = '{valid: accept & in_win,
                       we:    wr_go,
                       idx:   acc_addr[AddrWidth-1:2],
                       wdata: up_req_i.w_data,
                       wstrb: up_req_i.w_strb};

  always_comb begin
    up_rsp_o          = '0;
    up_rsp_o.aw_ready = idle & wr_go;
    up_rsp_o.w_ready  = idle & wr_go;
    up_rsp_o.ar_ready = idle & rd_go;
    up_rsp_o.b_valid  = (state_q == StResp) & is_wr_q;
    up_rsp_o.b_resp   = resp_q;
    up_rsp_o.r_valid  = (state_q == StResp) & ~is_wr_q;
    up_rsp_o.r_data   = rdata_q;
    up_rsp_o.r_resp   = resp_q;
  end

  assign rsp_done = (up_rsp_o.b_valid & up_req_i.b_ready) |
                    (up_rsp_o.r_valid & up_req_i.r_ready);

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      is_wr_q <= 1'b0;
    end else begin
      case (state_q)
        StIdle: if (accept) begin
          is_wr_q <= wr_go;
          state_q <= in_win ? StRam : StResp;   // Error answers next cycle
        end
        StRam:  if (ram_rsp_i.done) state_q <= StResp;
        StResp: if (rsp_done) state_q <= StIdle;
        default: state_q <= StIdle;
      endcase
    end
  end

  // Response payload
  always_ff @(posedge clk_aon) begin
    if (accept && !in_win) begin
      resp_q  <= RespSlvErr;
      rdata_q <= '0;
    end else if (state_q == StRam && ram_rsp_i.done) begin
      resp_q  <= RespOkay;
      rdata_q <= ram_rsp_i.rdata;
    end
  end

endmodule : ctn_addr_steer

// ==== hw/ctn_sram_adapter.sv ====
/*
 * Command to RAM adapter.
 * Issues one RAM request per command, expands strobes, fixed 3-cycle done.
 */
`timescale 1ns/1ps

module ctn_sram_adapter #(
  parameter int unsigned RamDepth = 256
) (
  input  logic                            clk_aon,
  input  logic                            rst_n_i,
  input  ctn_pkg::ram_cmd_t               cmd_i,
  output ctn_pkg::ram_rsp_t               rsp_o,
  output logic                            ram_req_o,
  output logic                            ram_we_o,
  output logic [$clog2(RamDepth)-1:0]     ram_addr_o,
  output logic [ctn_pkg::DataWidth-1:0]   ram_wdata_o,
  output logic [ctn_pkg::DataWidth-1:0]   ram_wmask_o,
  input  logic [ctn_pkg::DataWidth-1:0]   ram_rdata_i,
  input  logic                            ram_rvalid_i
);

  import ctn_pkg::*;

  localparam int unsigned WordAw = $clog2(RamDepth);

  logic [1:0]           cnt_q;    // Cycles left in the RAM pipeline
  logic [DataWidth-1:0] rdata_q;

  assign ram_req_o   = cmd_i.valid;   // RAM never stalls
  assign ram_we_o    = cmd_i.we;
  assign ram_addr_o  = cmd_i.idx[WordAw-1:0];
  assign ram_wdata_o = cmd_i.wdata;

  // One strobe bit covers eight data bits
  always_comb begin
    for (int i = 0; i < StrbWidth; i++) begin
      ram_wmask_o[8*i +: 8] = {8{cmd_i.wstrb[i]}};
    end
  end

  //////////////////////////////
  // Pipeline depth counter
  //////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      cnt_q <= 2'd0;
    end else if (cmd_i.valid) begin
      cnt_q <= 2'd3;
    end else if (cnt_q != 2'd0) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  // rvalid lands one cycle before done
  always_ff @(posedge clk_aon) begin
    if (ram_rvalid_i) begin
      rdata_q <= ram_rdata_i;
    end
  end

  assign rsp_o = '{done: (cnt_q == 2'd1), rdata: rdata_q};

endmodule : ctn_sram_adapter

// ==== hw/ctn_ram_1p.sv ====
/*
 * Single-port bit-masked RAM with input and output pipeline registers.
 */
`timescale 1ns/1ps

module ctn_ram_1p #(
  parameter int unsigned Depth = 256
) (
  input  logic                          clk_aon,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  logic                          write_i,
  input  logic [$clog2(Depth)-1:0]      addr_i,
  input  logic [ctn_pkg::DataWidth-1:0] wdata_i,
  input  logic [ctn_pkg::DataWidth-1:0] wmask_i,
  output logic [ctn_pkg::DataWidth-1:0] rdata_o,
  output logic                          rvalid_o
);

  import ctn_pkg::*;

  logic [DataWidth-1:0]     mem [Depth];
  logic                     req_q, we_q;
  logic [$clog2(Depth)-1:0] addr_q;
  logic [DataWidth-1:0]     wdata_q, wmask_q;

  // Input stage
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk_aon) begin
    we_q    <= write_i;
    addr_q  <= addr_i;
    wdata_q <= wdata_i;
    wmask_q <= wmask_i;
  end

  // Array access and output stage
  always_ff @(posedge clk_aon) begin
    if (req_q && we_q) begin
      mem[addr_q] <= (mem[addr_q] & ~wmask_q) | (wdata_q & wmask_q);
    end else if (req_q) begin
      rdata_o <= mem[addr_q];
    end
  end

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_q & ~we_q;   // Reads only
    end
  end

endmodule : ctn_ram_1p

// ==== hw/ctn_mem_top.sv ====
/*
 * CTN memory path top level.
 * Two AXI4-Lite hosts through arbiter and window steering into a scratch RAM.
 */
`timescale 1ns/1ps

module ctn_mem_top #(
  parameter int unsigned                   RamDepth = 256,
  parameter logic [ctn_pkg::AddrWidth-1:0] RamBase  = 32'h0001_0000
) (
  input  logic               clk_aon,
  input  logic               rst_n_i,
  input  ctn_pkg::axil_req_t host0_req_i,
  output ctn_pkg::axil_rsp_t host0_rsp_o,
  input  ctn_pkg::axil_req_t host1_req_i,
  output ctn_pkg::axil_rsp_t host1_rsp_o
);

  import ctn_pkg::*;

  localparam int unsigned RamAw = $clog2(RamDepth);

  axil_req_t            arb_req;
  axil_rsp_t            arb_rsp;
  ram_cmd_t             ram_cmd;
  ram_rsp_t             ram_rsp;
  logic                 ram_req, ram_we, ram_rvalid;
  logic [RamAw-1:0]     ram_addr;
  logic [DataWidth-1:0] ram_wdata, ram_wmask, ram_rdata;

  ctn_host_arb ctn_host_arb_i (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .host0_req_i (host0_req_i),
    .host0_rsp_o (host0_rsp_o),
    .host1_req_i (host1_req_i),
    .host1_rsp_o (host1_rsp_o),
    .dev_req_o   (arb_req),
    .dev_rsp_i   (arb_rsp)
  );

  ctn_addr_steer #(
    .RamDepth (RamDepth),
    .RamBase  (RamBase)
  ) ctn_addr_steer_i (
    .clk_aon   (clk_aon),
    .rst_n_i   (rst_n_i),
    .up_req_i  (arb_req),
    .up_rsp_o  (arb_rsp),
    .ram_cmd_o (ram_cmd),
    .ram_rsp_i (ram_rsp)
  );

  ctn_sram_adapter #(
    .RamDepth (RamDepth)
  ) ctn_sram_adapter_i (
    .clk_aon      (clk_aon),
    .rst_n_i      (rst_n_i),
    .cmd_i        (ram_cmd),
    .rsp_o        (ram_rsp),
    .ram_req_o    (ram_req),
    .ram_we_o     (ram_we),
    .ram_addr_o   (ram_addr),
    .ram_wdata_o  (ram_wdata),
    .ram_wmask_o  (ram_wmask),
    .ram_rdata_i  (ram_rdata),
    .ram_rvalid_i (ram_rvalid)
  );

  ctn_ram_1p #(
    .Depth (RamDepth)
  ) ctn_ram_1p_i (
    .clk_aon  (clk_aon),
    .rst_n_i  (rst_n_i),
    .req_i    (ram_req),
    .write_i  (ram_we),
    .addr_i   (ram_addr),
    .wdata_i  (ram_wdata),
    .wmask_i  (ram_wmask),
    .rdata_o  (ram_rdata),
    .rvalid_o (ram_rvalid)
  );

endmodule : ctn_mem_top

// ==== test/tb_ctn_mem_top.sv ====
/*
 * Directed testbench for the CTN memory path.
 * Two AXI4-Lite hosts, a word-level reference model and a watchdog.
 */
`timescale 1ns/1ps

module tb_ctn_mem_top;

  import ctn_pkg::*;

  localparam int unsigned RamDepth  = 256;
  localparam logic [31:0] RamBase   = 32'h0001_0000;
  localparam logic [31:0] WinBytes  = RamDepth * 4;
  localparam int unsigned ClkPeriod = 4;
  localparam int unsigned NumTxn    = 85;   // Sum over all tests below

  logic        clk_aon;
  logic        rst_n_i;
  axil_req_t   host_req [2];
  axil_rsp_t   host_rsp [2];
  logic [31:0] model [RamDepth];            // Expected RAM words
  integer      seed = 32'h9a544c51;
  int          err_cnt = 0;
  int          fail_tests = 0;
  int          test_cnt = 0;
  string       cur_test;

  ctn_mem_top #(
    .RamDepth (RamDepth),
    .RamBase  (RamBase)
  ) ctn_mem_top_i (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .host0_req_i (host_req[0]),
    .host0_rsp_o (host_rsp[0]),
    .host1_req_i (host_req[1]),
    .host1_rsp_o (host_rsp[1])
  );

  initial begin
    clk_aon = 1'b0;
    forever #(ClkPeriod / 2) clk_aon = ~clk_aon;
  end

  initial begin
    #((60 * NumTxn + 10) * ClkPeriod);
    $display("Watchdog expired, a transaction never completed");
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // Bus helpers
  //////////////////////////////

  // New bytes only in lanes whose strobe bit is set
  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic next_sample();
    @(negedge clk_aon);
    #1;                                     // Outputs settled mid low phase
  endtask

  task automatic issue_write(input int h, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold, output logic [1:0] resp);
    @(negedge clk_aon);
    host_req[h].aw_valid = 1'b1;
    host_req[h].aw_addr  = addr;
    host_req[h].w_valid  = 1'b1;
    host_req[h].w_data   = data;
    host_req[h].w_strb   = strb;
    #1;
    while (!(host_rsp[h].aw_ready && host_rsp[h].w_ready)) next_sample();
    @(negedge clk_aon);                     // Handshake on the edge before
    host_req[h].aw_valid = 1'b0;
    host_req[h].w_valid  = 1'b0;
    #1;
    while (!host_rsp[h].b_valid) next_sample();
    resp = host_rsp[h].b_resp;
    repeat (hold) begin
      next_sample();
      if (!host_rsp[h].b_valid) begin
        $display("%s: b_valid dropped while b_ready was low", cur_test);
        err_cnt++;
      end else if (host_rsp[h].b_resp != resp) begin
        $display("[ERROR] %s: held b_resp expected %h actual %h", cur_test, resp,
                 host_rsp[h].b_resp);
        err_cnt++;
      end
    end
    @(negedge clk_aon);
    host_req[h].b_ready = 1'b1;
    @(negedge clk_aon);
    host_req[h].b_ready = 1'b0;
  endtask

  task automatic issue_read(input int h, input logic [31:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
    @(negedge clk_aon);
    host_req[h].ar_valid = 1'b1;
    host_req[h].ar_addr  = addr;
    #1;
    while (!host_rsp[h].ar_ready) next_sample();
    @(negedge clk_aon);
    host_req[h].ar_valid = 1'b0;
    #1;
    while (!host_rsp[h].r_valid) next_sample();
    data = host_rsp[h].r_data;
    resp = host_rsp[h].r_resp;
    repeat (hold) begin
      next_sample();
      if (!host_rsp[h].r_valid) begin
        $display("%s: r_valid dropped while r_ready was low", cur_test);
        err_cnt++;
      end else if (host_rsp[h].r_data !== data) begin
        $display("[ERROR] %s: held r_data expected %h actual %h", cur_test, data,
                 host_rsp[h].r_data);
        err_cnt++;
      end
    end
    @(negedge clk_aon);
    host_req[h].r_ready = 1'b1;
    @(negedge clk_aon);
    host_req[h].r_ready = 1'b0;
  endtask

  task automatic write_word(input int h, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold);
    logic [1:0] resp;
    int         idx;
    idx = (addr - RamBase) >> 2;
    issue_write(h, addr, data, strb, hold, resp);
    if (resp != RespOkay) begin
      $display("[ERROR] %s: write %h resp expected %h actual %h", cur_test, addr, RespOkay,
               resp);
      err_cnt++;
    end
    model[idx] = merge_bytes(model[idx], data, strb);
  endtask

  task automatic read_check(input int h, input logic [31:0] addr, input int hold);
    logic [31:0] data;
    logic [1:0]  resp;
    int          idx;
    idx = (addr - RamBase) >> 2;
    issue_read(h, addr, hold, data, resp);
    if (resp != RespOkay) begin
      $display("[ERROR] %s: read %h resp expected %h actual %h", cur_test, addr, RespOkay,
               resp);
      err_cnt++;
    end
    if (data !== model[idx]) begin
      $display("[ERROR] %s: read %h expected %h actual %h", cur_test, addr, model[idx], data);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("%-16s PASS", cur_test);
    end else begin
      fail_tests++;
      $display("%-16s FAIL (%0d errors)", cur_test, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic write_readback();
    int e0 = err_cnt;
    cur_test = "write_readback";
    for (int i = 0; i < 4; i++) write_word(0, RamBase + 32'(i * 36), $random(seed), 4'hf, 0);
    for (int i = 0; i < 4; i++) read_check(0, RamBase + 32'(i * 36), 0);
    finish_test(e0);
  endtask

  task automatic masked_write();
    int e0 = err_cnt;
    cur_test = "masked_write";
    write_word(0, RamBase + 32'h80, 32'h1122_3344, 4'hf, 0);
    write_word(0, RamBase + 32'h80, 32'hAABB_CCDD, 4'b0101, 0);
    read_check(0, RamBase + 32'h80, 0);
    finish_test(e0);
  endtask

  task automatic out_of_window();
    int          e0 = err_cnt;
    logic [31:0] addr;
    logic [31:0] data;
    logic [1:0]  resp;
    cur_test = "out_of_window";
    // Words the two bad addresses would alias onto
    write_word(0, RamBase, 32'hCAFE_0000, 4'hf, 0);
    write_word(0, RamBase + WinBytes - 4, 32'hCAFE_00FF, 4'hf, 0);
    for (int i = 0; i < 2; i++) begin
      addr = (i == 0) ? RamBase - 4 : RamBase + WinBytes;
      issue_write(i, addr, 32'hDEAD_BEEF, 4'hf, 0, resp);
      if (resp != RespSlvErr) begin
        $display("[ERROR] %s: write %h resp expected %h actual %h", cur_test, addr,
                 RespSlvErr, resp);
        err_cnt++;
      end
      issue_read(i, addr, 0, data, resp);
      if (resp != RespSlvErr || data !== 32'h0) begin
        $display("[ERROR] %s: read %h expected %h/%h actual %h/%h", cur_test, addr,
                 RespSlvErr, 32'h0, resp, data);
        err_cnt++;
      end
    end
    read_check(0, RamBase, 0);
    read_check(0, RamBase + WinBytes - 4, 0);
    finish_test(e0);
  endtask

  task automatic dual_host();
    int e0 = err_cnt;
    cur_test = "dual_host";
    fork
      write_word(0, RamBase + 32'h100, 32'h0BAD_F00D, 4'hf, 0);
      write_word(1, RamBase + 32'h104, 32'h600D_CAFE, 4'hf, 0);
    join
    fork
      read_check(0, RamBase + 32'h104, 0);
      read_check(1, RamBase + 32'h100, 0);
    join
    finish_test(e0);
  endtask

  task automatic back_pressure();
    int          e0 = err_cnt;
    logic [31:0] addr;
    cur_test = "back_pressure";
    for (int i = 0; i < 3; i++) begin
      addr = RamBase + 32'h180 + 32'(4 * i);
      write_word(i % 2, addr, $random(seed), 4'hf, $unsigned($random(seed)) % 10 + 1);
      read_check(i % 2, addr, $unsigned($random(seed)) % 10 + 1);
    end
    finish_test(e0);
  endtask

  task automatic random_mix();
    int          e0 = err_cnt;
    int          h;
    logic [31:0] addr;
    cur_test = "random_mix";
    for (int i = 0; i < 16; i++) begin
      write_word(i % 2, RamBase + 32'h200 + 32'(4 * i), $random(seed), 4'hf, 0);
    end
    for (int i = 0; i < 40; i++) begin
      h    = $unsigned($random(seed)) % 2;
      addr = RamBase + 32'h200 + 32'(4 * ($unsigned($random(seed)) % 16));
      if ($random(seed) & 1) begin
        write_word(h, addr, $random(seed), 4'($random(seed)), 0);
      end else begin
        read_check(h, addr, 0);
      end
    end
    finish_test(e0);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    host_req[0] = '0;
    host_req[1] = '0;
    repeat (10) @(negedge clk_aon);
    rst_n_i = 1'b1;
    write_readback();
    masked_write();
    out_of_window();
    dual_host();
    back_pressure();
    random_mix();
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_ctn_mem_top

// ==== ctn_mem.f ====
hw/ctn_pkg.sv
hw/ctn_host_arb.sv
hw/ctn_addr_steer.sv
hw/ctn_sram_adapter.sv
hw/ctn_ram_1p.sv
hw/ctn_mem_top.sv
test/tb_ctn_mem_top.sv

// ==== Bender.yml ====
package:
  name: ctn_mem

sources:
  - files:
      - hw/ctn_pkg.sv
      - hw/ctn_host_arb.sv
      - hw/ctn_addr_steer.sv
      - hw/ctn_sram_adapter.sv
      - hw/ctn_ram_1p.sv
      - hw/ctn_mem_top.sv
  - target: test
    files:
      - test/tb_ctn_mem_top.sv
